// ==== tests/dagTrace.txt ====
# name go op dst iSel mSel dagEn redo dmdIn newI expDmdOut expOpI expOpL expOpM check
# op: 0 none 1 wrI 2 wrL 3 wrM 4 rdI 5 rdL 6 rdM 7 postModify; numbers are hex
reset     1 0 0 0 0 0 0 0000 0000 0000 0000 0000 0000 1
writeRegs 1 1 0 0 0 0 0 0000 0000 0000 0000 0000 0000 1
writeRegs 1 1 1 0 0 0 0 0123 0000 0000 0000 0000 0000 1
writeRegs 1 2 0 0 0 0 0 2abc 0000 0000 0000 0000 0000 1
writeRegs 1 2 1 0 0 0 0 0040 0000 0000 0000 0000 0000 1
writeRegs 1 3 0 0 0 0 0 1fff 0000 0000 0000 0000 0000 1
writeRegs 1 3 1 0 0 0 0 2004 0000 0000 0000 0000 0000 1
readBack  1 4 0 0 0 0 0 0005 0000 0000 0000 0000 0000 1
readBack  1 4 1 0 0 0 0 0000 0000 0123 0000 0000 0000 1
readBack  1 5 0 0 0 0 0 0000 0000 2abc 0000 0000 0000 1
readBack  1 5 1 0 0 0 0 0000 0000 0040 0000 0000 0000 1
readBack  1 6 0 0 0 0 0 0000 0000 1fff 0000 0000 0000 1
readBack  1 6 1 0 0 0 0 0000 0000 e004 0000 0000 0000 1
fetch     1 0 0 1 0 1 0 0000 0000 0005 0000 0000 0000 1
fetch     1 0 0 0 1 1 0 0000 0000 0000 2abc 1fff 2004 1
fetch     1 0 0 0 0 0 0 0000 0000 0000 0123 0040 0005 1
fwdI      1 1 2 0 0 0 0 0000 0000 0000 0123 0040 0005 1
fwdI      1 2 2 2 0 1 0 3111 0000 0000 0123 0040 0005 1
fwdL      1 3 3 2 3 1 0 0777 0000 0000 3111 0000 2004 1
fwdM      1 0 0 0 3 1 0 3ffe 0000 0000 3111 0777 0000 1
postMod   1 7 3 0 0 0 0 0000 0000 0000 0123 0040 3ffe 1
postMod   1 4 3 0 0 0 0 0999 1234 0000 0123 0040 3ffe 1
postMod   1 0 0 3 1 1 0 0000 0000 1234 0123 0040 3ffe 1
pmFwd     1 7 0 0 0 0 0 0000 0000 0000 1234 0000 0005 1
pmFwd     1 0 0 0 0 1 0 0000 0200 0000 1234 0000 0005 1
pmFwd     1 0 0 0 0 0 0 0000 0000 0000 0200 0040 2004 1
stall     1 1 1 1 0 0 0 0000 0000 0000 0200 0040 2004 1
stall     0 0 0 1 1 1 0 0aaa 0000 0000 0200 0040 2004 1
stall     0 0 0 2 0 1 0 0bbb 0000 0000 0200 0040 2004 1
redo      0 0 0 3 3 1 1 0ccc 0000 0000 0200 0040 2004 1
redo      0 0 0 0 0 0 0 0000 0000 0000 2abc 1fff 2004 1
resume    1 0 0 0 0 0 0 0ddd 0000 0000 2abc 1fff 2004 1
resume    1 4 1 0 0 0 0 0000 0000 0000 2abc 1fff 2004 1
resume    1 0 0 1 2 1 0 0000 0000 0ddd 2abc 1fff 2004 1
readStall 1 6 3 0 0 0 0 0000 0000 0000 0ddd 1fff 0000 1
readStall 0 0 0 0 0 0 0 0000 0000 fffe 0ddd 1fff 0000 1
readStall 0 0 0 0 0 0 0 0000 0000 fffe 0ddd 1fff 0000 1
readStall 1 0 0 0 0 0 0 0000 0000 fffe 0ddd 1fff 0000 1
end       1 0 0 0 0 0 0 0000 0000 0000 0ddd 1fff 0000 1

// ==== tb.f ====
hw/dagPkg.sv
hw/dagExecStage.sv
hw/dagRegBank.sv
hw/dagOperandStage.sv
hw/dagTop.sv
tests/dagTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module dagTb -o dagSim

out=$(./obj_dir/dagSim)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

// ==== tests/dagTb.sv ====
`default_nettype none

module dagTb;

  timeunit 1ns;
  timeprecision 1ps;

  // One cycle of stimulus together with the outputs expected during that cycle.
  typedef struct packed {
    logic [8*16-1:0]    name;
    logic               go;
    dagPkg::dagCmdT     cmd;
    logic               redo;
    dagPkg::addrT       dmdIn;
    dagPkg::addrT       newI;
    dagPkg::dataT       expDmdOut;
    dagPkg::dagOperandT expOperand;
    logic               check;
  } traceLineT;

  logic               DSPCLK;
  logic               RST;
  logic               go;
  dagPkg::dagCmdT     fetchCmd;
  logic               redo;
  dagPkg::addrT       dmdIn;
  dagPkg::addrT       newI;
  dagPkg::dataT       dmdOut;
  dagPkg::dagOperandT operand;

  traceLineT trace[$];
  int        errorCount;
  int        checkCount;
  int        cycleCount;
  int        cycleLimit;
  logic      traceOk;

  dagTop u_dagTop (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .go       (go),
    .fetchCmd (fetchCmd),
    .redo     (redo),
    .dmdIn    (dmdIn),
    .newI     (newI),
    .dmdOut   (dmdOut),
    .operand  (operand)
  );

  initial
  begin
    DSPCLK = 1'b0;
    forever #10 DSPCLK = ~DSPCLK;
  end

  // Reads the trace, skipping comment lines that start with #.
  task automatic loadTrace(output logic ok);
    int          fd;
    int          fields;
    string       line;
    traceLineT   t;
    logic [8*16-1:0] nameV;
    logic [31:0] goV, opV, dstV, iV, mV, enV, redoV;
    logic [31:0] dinV, niV, eD, eI, eL, eM, chkV;
    ok = 1'b1;
    fd = $fopen("tests/dagTrace.txt", "r");
    if (fd == 0)
    begin
      $display("Trace file tests/dagTrace.txt could not be opened.");
      errorCount++;
      ok = 1'b0;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() < 2 || line.getc(0) == "#")
        begin
          continue;
        end
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         nameV, goV, opV, dstV, iV, mV, enV, redoV,
                         dinV, niV, eD, eI, eL, eM, chkV);
        if (fields != 15)
        begin
          $display("Trace line has %0d fields instead of 15: %s", fields, line);
          errorCount++;
          ok = 1'b0;
        end
        else
        begin
          t.name         = nameV;
          t.go           = goV[0];
          t.cmd.op       = dagPkg::dagOpT'(opV[2:0]);
          t.cmd.dstSel   = dstV[1:0];
          t.cmd.iSel     = iV[1:0];
          t.cmd.mSel     = mV[1:0];
          t.cmd.dagEn    = enV[0];
          t.redo         = redoV[0];
          t.dmdIn        = dinV[13:0];
          t.newI         = niV[13:0];
          t.expDmdOut    = eD[15:0];
          t.expOperand.i = eI[13:0];
          t.expOperand.l = eL[13:0];
          t.expOperand.m = eM[13:0];
          t.check        = chkV[0];
          trace.push_back(t);
        end
      end
      $fclose(fd);
      if (trace.size() == 0)
      begin
        $display("Trace file holds no stimulus lines.");
        errorCount++;
        ok = 1'b0;
      end
    end
  endtask

  task automatic applyLine(input traceLineT t);
    @(posedge DSPCLK);
    go       <= t.go;
    fetchCmd <= t.cmd;
    redo     <= t.redo;
    dmdIn    <= t.dmdIn;
    newI     <= t.newI;
  endtask

  // Outputs have settled by the falling edge.
  task automatic checkLine(input traceLineT t);
    checkCount += 4;
    assert (dmdOut === t.expDmdOut)
    else
    begin
      errorCount++;
      $display("CHECK FAILED %0s dmdOut expected %h actual %h",
               t.name, t.expDmdOut, dmdOut);
    end
    assert (operand.i === t.expOperand.i)
    else
    begin
      errorCount++;
      $display("CHECK FAILED %0s operand.i expected %h actual %h",
               t.name, t.expOperand.i, operand.i);
    end
    assert (operand.l === t.expOperand.l)
    else
    begin
      errorCount++;
      $display("CHECK FAILED %0s operand.l expected %h actual %h",
               t.name, t.expOperand.l, operand.l);
    end
    assert (operand.m === t.expOperand.m)
    else
    begin
      errorCount++;
      $display("CHECK FAILED %0s operand.m expected %h actual %h",
               t.name, t.expOperand.m, operand.m);
    end
  endtask

  initial
  begin
    RST        = 1'b1;
    go         = 1'b0;
    fetchCmd   = '0;
    redo       = 1'b0;
    dmdIn      = '0;
    newI       = '0;
    errorCount = 0;
    checkCount = 0;
    loadTrace(traceOk);
    cycleLimit = trace.size() + 20;   // Reset cycles fit in the margin.
    if (traceOk)
    begin
      repeat (5) @(posedge DSPCLK);
      RST <= 1'b0;
      foreach (trace[n])
      begin
        applyLine(trace[n]);
        @(negedge DSPCLK);
        if (trace[n].check)
        begin
          checkLine(trace[n]);
        end
      end
    end
    $display("Checks run %0d, errors %0d.", checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

  always @(posedge DSPCLK)
  begin
    cycleCount++;
    if (cycleCount > cycleLimit)
    begin
      $display("Timeout after %0d cycles, the trace did not complete.", cycleLimit);
      $display("Checks run %0d, errors %0d.", checkCount, errorCount);
      $display("test failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== hw/dagTop.sv ====
`default_nettype none

module dagTop (
  input  logic               DSPCLK,
  input  logic               RST,
  input  logic               go,
  input  dagPkg::dagCmdT     fetchCmd,
  input  logic               redo,
  input  dagPkg::addrT       dmdIn,
  input  dagPkg::addrT       newI,
  output dagPkg::dataT       dmdOut,
  output dagPkg::dagOperandT operand
);

  dagPkg::dagSelT  fetchSel;
  dagPkg::dagSelT  execSel;
  dagPkg::dagLoadT ld;
  dagPkg::dagReadT rd;
  dagPkg::dagBankT bank;
  dagPkg::addrT    wrI;

  assign fetchSel = '{iSel: fetchCmd.iSel, mSel: fetchCmd.mSel};

  dagExecStage uExecStage (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .go       (go),
    .fetchCmd (fetchCmd),
    .execSel  (execSel),
    .ld       (ld),
    .rd       (rd)
  );

  dagRegBank uRegBank (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .ld     (ld),
    .rd     (rd),
    .dmdIn  (dmdIn),
    .newI   (newI),
    .bank   (bank),
    .wrI    (wrI),
    .dmdOut (dmdOut)
  );

  // The bus word doubles as the L and M write data for forwarding.
  dagOperandStage uOperandStage (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .go       (go),
    .redo     (redo),
    .fetchSel (fetchSel),
    .dagEn    (fetchCmd.dagEn),
    .execSel  (execSel),
    .ld       (ld),
    .bank     (bank),
    .wrI      (wrI),
    .dmdIn    (dmdIn),
    .operand  (operand)
  );

endmodule

`default_nettype wire

// ==== hw/dagOperandStage.sv ====
`default_nettype none

module dagOperandStage (
  input  logic               DSPCLK,
  input  logic               RST,
  input  logic               go,
  input  logic               redo,
  input  dagPkg::dagSelT     fetchSel,
  input  logic               dagEn,
  input  dagPkg::dagSelT     execSel,
  input  dagPkg::dagLoadT    ld,
  input  dagPkg::dagBankT    bank,
  input  dagPkg::addrT       wrI,
  input  dagPkg::addrT       dmdIn,
  output dagPkg::dagOperandT operand
);

  dagPkg::regSelT     iSel;
  dagPkg::regSelT     mSel;
  dagPkg::dagOperandT nextOperand;
  logic               loadOperand;

  // Picks the selected register, or its write data when it is loaded at this edge.
  function automatic dagPkg::addrT forward(
    input dagPkg::addrT [dagPkg::NumRegs-1:0] regs,
    input dagPkg::regMaskT                    ldMask,
    input dagPkg::regSelT                     sel,
    input dagPkg::addrT                       wrData
  );
    dagPkg::addrT result;
    if (ldMask[sel])
    begin
      result = wrData;
    end
    else
    begin
      result = regs[sel];
    end
    return result;
  endfunction

  // A replay reuses the selects of the instruction already in execute.
  assign iSel = redo ? execSel.iSel : fetchSel.iSel;
  assign mSel = redo ? execSel.mSel : fetchSel.mSel;

  always_comb
  begin
    nextOperand.i = forward(bank.i, ld.ldI, iSel, wrI);
    nextOperand.l = forward(bank.l, ld.ldL, iSel, dmdIn);   // L pairs with I.
    nextOperand.m = forward(bank.m, ld.ldM, mSel, dmdIn);
  end

  assign loadOperand = (go && dagEn) || redo;

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      operand <= '0;
    end
    else if (loadOperand)
    begin
      operand <= nextOperand;
    end
  end

  // Selects and masks from fetch and execute must all resolve to known values.
  operandKnown: assert property (@(posedge DSPCLK) disable iff (RST)
    !$isunknown(operand));

endmodule

`default_nettype wire

// ==== hw/dagRegBank.sv ====
`default_nettype none

module dagRegBank (
  input  logic            DSPCLK,
  input  logic            RST,
  input  dagPkg::dagLoadT ld,
  input  dagPkg::dagReadT rd,
  input  dagPkg::addrT    dmdIn,
  input  dagPkg::addrT    newI,
  output dagPkg::dagBankT bank,
  output dagPkg::addrT    wrI,
  output dagPkg::dataT    dmdOut
);

  localparam int ExtWidth = dagPkg::DataWidth - dagPkg::AddrWidth;

  dagPkg::addrT iVal;
  dagPkg::addrT lVal;
  dagPkg::addrT mVal;

  // A post-modify writes back the index computed outside this block.
  assign wrI = ld.useNewI ? newI : dmdIn;

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      bank <= '0;
    end
    else
    begin
      for (int n = 0; n < dagPkg::NumRegs; n++)
      begin
        if (ld.ldI[n])
        begin
          bank.i[n] <= wrI;
        end
        if (ld.ldL[n])
        begin
          bank.l[n] <= dmdIn;
        end
        if (ld.ldM[n])
        begin
          bank.m[n] <= dmdIn;
        end
      end
    end
  end

  // Readback is an AND-OR of the masked registers, so no mask gives zero.
  always_comb
  begin
    iVal = '0;
    lVal = '0;
    mVal = '0;
    for (int n = 0; n < dagPkg::NumRegs; n++)
    begin
      iVal = iVal | ({dagPkg::AddrWidth{rd.rdI[n]}} & bank.i[n]);
      lVal = lVal | ({dagPkg::AddrWidth{rd.rdL[n]}} & bank.l[n]);
      mVal = mVal | ({dagPkg::AddrWidth{rd.rdM[n]}} & bank.m[n]);
    end
  end

  // Modify values are signed, index and length values are not.
  assign dmdOut = {{ExtWidth{1'b0}}, iVal | lVal}
                | {{ExtWidth{mVal[dagPkg::AddrWidth-1]}}, mVal};

  // The zero and sign extensions would merge if two kinds drove the bus.
  singleRead: assert property (@(posedge DSPCLK) disable iff (RST)
    $onehot0({rd.rdI, rd.rdL, rd.rdM}));

endmodule

`default_nettype wire

// ==== hw/dagExecStage.sv ====
`default_nettype none

module dagExecStage (
  input  logic            DSPCLK,
  input  logic            RST,
  input  logic            go,
  input  dagPkg::dagCmdT  fetchCmd,
  output dagPkg::dagSelT  execSel,
  output dagPkg::dagLoadT ld,
  output dagPkg::dagReadT rd
);

  dagPkg::dagOpT   execOp;
  dagPkg::regSelT  execDst;
  dagPkg::regMaskT dstMask;
  dagPkg::regMaskT writeMask;

  // Execute register. It holds its command for as long as go stays low.
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      execOp  <= dagPkg::opNone;
      execDst <= '0;
      execSel <= '0;
    end
    else if (go)
    begin
      execOp       <= fetchCmd.op;
      execDst      <= fetchCmd.dstSel;
      execSel.iSel <= fetchCmd.iSel;
      execSel.mSel <= fetchCmd.mSel;
    end
  end

  assign dstMask   = dagPkg::regMaskT'(1) << execDst;
  assign writeMask = go ? dstMask : '0;   // A stalled write must not land.

  always_comb
  begin
    ld = '0;
    rd = '0;
    case (execOp)
      dagPkg::opWriteI: ld.ldI = writeMask;
      dagPkg::opWriteL: ld.ldL = writeMask;
      dagPkg::opWriteM: ld.ldM = writeMask;
      dagPkg::opReadI:  rd.rdI = dstMask;
      dagPkg::opReadL:  rd.rdL = dstMask;
      dagPkg::opReadM:  rd.rdM = dstMask;
      dagPkg::opPostModify:
      begin
        ld.ldI     = writeMask;
        ld.useNewI = 1'b1;
      end
      default: ;
    endcase
  end

  // Forwarding in the operand stage relies on at most one target per kind.
  maskOneHot: assert property (@(posedge DSPCLK) disable iff (RST)
    $onehot0(ld.ldI) && $onehot0(ld.ldL) && $onehot0(ld.ldM) &&
    $onehot0(rd.rdI) && $onehot0(rd.rdL) && $onehot0(rd.rdM));

  // The bank stays frozen through a stall.
  noWriteInStall: assert property (@(posedge DSPCLK) disable iff (RST)
    !go |-> (ld.ldI == '0 && ld.ldL == '0 && ld.ldM == '0));

endmodule

`default_nettype wire

// ==== hw/dagPkg.sv ====
`default_nettype none

package dagPkg;

  localparam int AddrWidth = 14;
  localparam int DataWidth = 16;
  localparam int NumRegs = 4;

  typedef logic [AddrWidth-1:0] addrT;
  typedef logic [DataWidth-1:0] dataT;
  typedef logic [1:0] regSelT;
  typedef logic [NumRegs-1:0] regMaskT;

  // Register operations carried from fetch into the execute stage.
  typedef enum logic [2:0] {
    opNone,
    opWriteI,
    opWriteL,
    opWriteM,
    opReadI,
    opReadL,
    opReadM,
    opPostModify
  } dagOpT;

  typedef struct packed {
    dagOpT op;
    regSelT dstSel;   // Register targeted by op.
    regSelT iSel;
    regSelT mSel;
    logic dagEn;      // Instruction needs an address from the generator.
  } dagCmdT;

  typedef struct packed {
    regSelT iSel;
    regSelT mSel;
  } dagSelT;

  typedef struct packed {
    regMaskT ldI;
    regMaskT ldL;
    regMaskT ldM;
    logic useNewI;    // I write data comes from newI instead of the bus.
  } dagLoadT;

  typedef struct packed {
    regMaskT rdI;
    regMaskT rdL;
    regMaskT rdM;
  } dagReadT;

  typedef struct packed {
    addrT [NumRegs-1:0] i;
    addrT [NumRegs-1:0] l;
    addrT [NumRegs-1:0] m;
  } dagBankT;

  typedef struct packed {
    addrT i;
    addrT l;
    addrT m;
  } dagOperandT;

endpackage

`default_nettype wire
